// File: rtl/axi3_pkg.sv
package axi3_pkg;

	localparam logic [1:0] AXI_BURST_INCR = 2'b01;

	localparam logic [3:0] ID_INST = 4'd0; // icache refills
	localparam logic [3:0] ID_DATA = 4'd1; // loads and stores

	// address channels, valid travels separately
	typedef struct packed {
		logic [3:0]  id;
		logic [31:0] addr;
		logic [7:0]  len;
		logic [2:0]  size;
		logic [1:0]  burst;
		logic [1:0]  lock;
		logic [3:0]  cache;
		logic [2:0]  prot;
	} axi_ar_t;

	typedef struct packed {
		logic [3:0]  id;
		logic [31:0] addr;
		logic [7:0]  len;
		logic [2:0]  size;
		logic [1:0]  burst;
		logic [1:0]  lock;
		logic [3:0]  cache;
		logic [2:0]  prot;
	} axi_aw_t;

	typedef struct packed {
		logic [3:0]  id;
		logic [31:0] data;
		logic [3:0]  strb;
		logic        last;
	} axi_w_t;

	typedef struct packed {
		logic [3:0]  id;
		logic [31:0] data;
		logic [1:0]  resp;
		logic        last;
	} axi_r_t;

	typedef struct packed {
		logic [3:0] id;
		logic [1:0] resp;
	} axi_b_t;

endpackage

// File: rtl/cpu_mem_pkg.sv
package cpu_mem_pkg;

	typedef enum logic [1:0] {
		REQ_IFETCH,
		REQ_LOAD,
		REQ_STORE
	} req_kind_e;

	// one request as seen by the channel engines
	typedef struct packed {
		req_kind_e   kind;
		logic [31:0] addr;
		logic [1:0]  size;  // 0 byte, 1 half, 2 word
		logic [31:0] wdata;
		logic [3:0]  wstrb;
	} mem_req_t;

	typedef enum logic [1:0] {
		RD_IDLE,
		RD_ADDR,
		RD_DONE // lets the cpu drop its request after the handshake
	} rd_state_e;

	typedef enum logic [2:0] {
		WR_IDLE,
		WR_BOTH,
		WR_WAIT_W,
		WR_WAIT_AW,
		WR_WAIT_B
	} wr_state_e;

endpackage

// File: rtl/mem_req_decode.sv
`timescale 1ns/1ps

module mem_req_decode
	import cpu_mem_pkg::*;
#(
	parameter int IFETCH_BEATS = 4
) (
	input  logic        aclk,
	input  logic        aresetn,
	input  logic        icache_rd_req,
	input  logic [31:0] icache_rd_addr,
	input  logic        data_sram_req,
	input  logic        data_sram_wr,
	input  logic [1:0]  data_sram_size,
	input  logic [31:0] data_sram_addr,
	input  logic [31:0] data_sram_wdata,
	input  logic [3:0]  data_sram_wstrb,
	input  logic        wr_pend_valid,
	input  logic [31:0] wr_pend_addr,
	output mem_req_t    rd_req,
	output logic        rd_req_valid,
	input  logic        rd_req_taken,
	output mem_req_t    wr_req,
	output logic        wr_req_valid,
	input  logic        wr_req_taken
);

	logic        load_hit;
	logic        fetch_hit;
	logic        load_go;
	logic        fetch_go;
	logic        store_go;
	logic [29:0] fetch_off; // pending store word minus refill start word

	assign load_hit = wr_pend_valid && (wr_pend_addr[31:2] == data_sram_addr[31:2]);
	// a refill covers IFETCH_BEATS words starting at its own address
	assign fetch_off = wr_pend_addr[31:2] - icache_rd_addr[31:2];
	assign fetch_hit = wr_pend_valid && (fetch_off < 30'(IFETCH_BEATS));

	assign load_go  = data_sram_req && !data_sram_wr && !load_hit;
	assign fetch_go = icache_rd_req && !fetch_hit;
	assign store_go = data_sram_req && data_sram_wr;

	// descriptors follow the cpu levels every cycle; an engine only looks when idle
	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			rd_req_valid <= 1'b0;
			wr_req_valid <= 1'b0;
		end else begin
			rd_req_valid <= !rd_req_taken && (load_go || fetch_go);
			wr_req_valid <= !wr_req_taken && store_go;
		end
	end

	always_ff @(posedge aclk) begin
		if (load_go) begin // loads win over refills
			rd_req <= '{kind: REQ_LOAD, addr: data_sram_addr, size: data_sram_size,
				wdata: '0, wstrb: '0};
		end else begin
			rd_req <= '{kind: REQ_IFETCH, addr: icache_rd_addr, size: 2'b10,
				wdata: '0, wstrb: '0};
		end
		wr_req <= '{kind: REQ_STORE, addr: data_sram_addr, size: data_sram_size,
			wdata: data_sram_wdata, wstrb: data_sram_wstrb};
	end

endmodule

// File: rtl/axi_read_engine.sv
`timescale 1ns/1ps

module axi_read_engine
	import axi3_pkg::*;
	import cpu_mem_pkg::*;
#(
	parameter int IFETCH_BEATS = 4
) (
	input  logic     aclk,
	input  logic     aresetn,
	input  mem_req_t rd_req,
	input  logic     rd_req_valid,
	output logic     rd_req_taken,
	output axi_ar_t  m_ar,
	output logic     m_arvalid,
	input  logic     m_arready,
	input  axi_r_t   m_r,
	input  logic     m_rvalid,
	output logic     m_rready,
	output logic     ar_fire,
	output logic     r_fire
);

	rd_state_e  state;
	logic [1:0] rd_outstanding; // address handshakes without their last beat
	logic       is_fetch;

	assign is_fetch = (rd_req.kind == REQ_IFETCH);

	// at most three reads in flight
	assign rd_req_taken = (state == RD_IDLE) && rd_req_valid && (rd_outstanding != 2'd3);

	assign m_arvalid = (state == RD_ADDR);
	assign ar_fire   = m_arvalid && m_arready;
	assign m_rready  = (rd_outstanding != 2'd0);
	assign r_fire    = m_rvalid && m_rready;

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			state <= RD_IDLE;
		end else begin
			case (state)
				RD_IDLE: begin
					if (rd_req_taken)
						state <= RD_ADDR;
				end
				RD_ADDR: begin
					if (ar_fire)
						state <= RD_DONE;
				end
				RD_DONE: state <= RD_IDLE;
				default: state <= RD_IDLE;
			endcase
		end
	end

	always_ff @(posedge aclk) begin
		if (rd_req_taken) begin
			m_ar.id    <= is_fetch ? ID_INST : ID_DATA;
			m_ar.addr  <= rd_req.addr;
			m_ar.len   <= is_fetch ? 8'(IFETCH_BEATS - 1) : 8'd0;
			m_ar.size  <= {1'b0, rd_req.size};
			m_ar.burst <= AXI_BURST_INCR;
			m_ar.lock  <= 2'b00;
			m_ar.cache <= 4'b0000;
			m_ar.prot  <= 3'b000;
		end
	end

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			rd_outstanding <= 2'd0;
		end else begin
			case ({ar_fire, r_fire && m_r.last})
				2'b10:   rd_outstanding <= rd_outstanding + 2'd1;
				2'b01:   rd_outstanding <= rd_outstanding - 2'd1;
				default: rd_outstanding <= rd_outstanding; // none, or one in and one out
			endcase
		end
	end

endmodule

// File: rtl/axi_write_engine.sv
`timescale 1ns/1ps

module axi_write_engine
	import axi3_pkg::*;
	import cpu_mem_pkg::*;
(
	input  logic        aclk,
	input  logic        aresetn,
	input  mem_req_t    wr_req,
	input  logic        wr_req_valid,
	output logic        wr_req_taken,
	output axi_aw_t     m_aw,
	output logic        m_awvalid,
	input  logic        m_awready,
	output axi_w_t      m_w,
	output logic        m_wvalid,
	input  logic        m_wready,
	input  axi_b_t      m_b,
	input  logic        m_bvalid,
	output logic        m_bready,
	output logic        aw_fire,
	output logic        b_fire,
	output logic        wr_pend_valid,
	output logic [31:0] wr_pend_addr
);

	wr_state_e state;
	logic      w_fire;

	assign wr_req_taken = (state == WR_IDLE) && wr_req_valid;

	assign m_awvalid = (state == WR_BOTH) || (state == WR_WAIT_AW);
	assign m_wvalid  = (state == WR_BOTH) || (state == WR_WAIT_W);
	assign m_bready  = (state == WR_WAIT_B);

	assign aw_fire = m_awvalid && m_awready;
	assign w_fire  = m_wvalid && m_wready;
	assign b_fire  = m_bvalid && m_bready && (m_b.id == ID_DATA); // resp ignored

	// store is pending from acceptance until its response
	assign wr_pend_valid = (state != WR_IDLE);
	assign wr_pend_addr  = m_aw.addr;

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			state <= WR_IDLE;
		end else begin
			case (state)
				WR_IDLE: begin
					if (wr_req_taken)
						state <= WR_BOTH;
				end
				WR_BOTH: begin
					if (aw_fire && w_fire)
						state <= WR_WAIT_B;
					else if (aw_fire)
						state <= WR_WAIT_W;
					else if (w_fire)
						state <= WR_WAIT_AW;
				end
				WR_WAIT_W: begin
					if (w_fire)
						state <= WR_WAIT_B;
				end
				WR_WAIT_AW: begin
					if (aw_fire)
						state <= WR_WAIT_B;
				end
				WR_WAIT_B: begin
					if (b_fire)
						state <= WR_IDLE;
				end
				default: state <= WR_IDLE;
			endcase
		end
	end

	always_ff @(posedge aclk) begin
		if (wr_req_taken) begin
			m_aw <= '{id: ID_DATA, addr: wr_req.addr, len: 8'd0, size: {1'b0, wr_req.size},
				burst: AXI_BURST_INCR, lock: 2'b00, cache: 4'b0000, prot: 3'b000};
			m_w  <= '{id: ID_DATA, data: wr_req.wdata, strb: wr_req.wstrb, last: 1'b1};
		end
	end

endmodule

// File: rtl/mem_resp_return.sv
`timescale 1ns/1ps

module mem_resp_return
	import axi3_pkg::*;
#(
	parameter int IFETCH_BEATS = 4
) (
	input  logic        aclk,
	input  logic        aresetn,
	input  logic        ar_fire,
	input  logic [3:0]  ar_id,
	input  logic        aw_fire,
	input  logic        b_fire,
	input  logic        r_fire,
	input  axi_r_t      m_r,
	output logic        icache_rd_rdy,
	output logic        icache_ret_valid,
	output logic        icache_ret_last,
	output logic [31:0] icache_ret_data,
	output logic        data_sram_addr_ok,
	output logic        data_sram_data_ok,
	output logic [31:0] data_sram_rdata
);

	logic [31:0] rbuf [2]; // slot 0 refill, slot 1 data
	logic        beat_q;   // a beat arrived last cycle
	logic [3:0]  rid_q;
	logic        rlast_q;
	logic        cnt_end_q;
	logic [4:0]  beat_cnt; // refill beats so far
	logic        fetch_end;

	assign fetch_end = (beat_cnt == 5'(IFETCH_BEATS - 1));

	always_ff @(posedge aclk) begin
		if (r_fire) begin
			rbuf[m_r.id[0]] <= m_r.data;
			rid_q           <= m_r.id;
			rlast_q         <= m_r.last;
			cnt_end_q       <= fetch_end;
		end
	end

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			beat_q   <= 1'b0;
			beat_cnt <= 5'd0;
		end else begin
			beat_q <= r_fire;
			if (r_fire && m_r.id == ID_INST)
				beat_cnt <= (m_r.last || fetch_end) ? 5'd0 : beat_cnt + 5'd1;
		end
	end

	assign icache_rd_rdy     = ar_fire && (ar_id == ID_INST);
	assign data_sram_addr_ok = (ar_fire && (ar_id == ID_DATA)) || aw_fire;

	assign icache_ret_valid = beat_q && (rid_q == ID_INST);
	// a burst longer than IFETCH_BEATS still closes the refill at the expected count
	assign icache_ret_last   = icache_ret_valid && (rlast_q || cnt_end_q);
	assign icache_ret_data   = rbuf[0];
	assign data_sram_data_ok = (beat_q && (rid_q == ID_DATA) && rlast_q) || b_fire;
	assign data_sram_rdata   = rbuf[1];

endmodule

// File: rtl/sram_axi_bridge.sv
`timescale 1ns/1ps

module sram_axi_bridge
	import axi3_pkg::*;
	import cpu_mem_pkg::*;
#(
	parameter int IFETCH_BEATS = 4
) (
	input  logic        aclk,
	input  logic        aresetn,
	input  logic        icache_rd_req,
	input  logic [31:0] icache_rd_addr,
	output logic        icache_rd_rdy,
	output logic        icache_ret_valid,
	output logic        icache_ret_last,
	output logic [31:0] icache_ret_data,
	input  logic        data_sram_req,
	input  logic        data_sram_wr,
	input  logic [1:0]  data_sram_size,
	input  logic [31:0] data_sram_addr,
	input  logic [31:0] data_sram_wdata,
	input  logic [3:0]  data_sram_wstrb,
	output logic        data_sram_addr_ok,
	output logic        data_sram_data_ok,
	output logic [31:0] data_sram_rdata,
	output axi_ar_t     m_ar,
	output logic        m_arvalid,
	input  logic        m_arready,
	input  axi_r_t      m_r,
	input  logic        m_rvalid,
	output logic        m_rready,
	output axi_aw_t     m_aw,
	output logic        m_awvalid,
	input  logic        m_awready,
	output axi_w_t      m_w,
	output logic        m_wvalid,
	input  logic        m_wready,
	input  axi_b_t      m_b,
	input  logic        m_bvalid,
	output logic        m_bready
);

	mem_req_t    rd_req;
	logic        rd_req_valid;
	logic        rd_req_taken;
	mem_req_t    wr_req;
	logic        wr_req_valid;
	logic        wr_req_taken;
	logic        wr_pend_valid;
	logic [31:0] wr_pend_addr;
	logic        ar_fire;
	logic        r_fire;
	logic        aw_fire;
	logic        b_fire;

	mem_req_decode #(.IFETCH_BEATS(IFETCH_BEATS)) i_decode (
		.aclk, .aresetn,
		.icache_rd_req, .icache_rd_addr,
		.data_sram_req, .data_sram_wr, .data_sram_size,
		.data_sram_addr, .data_sram_wdata, .data_sram_wstrb,
		.wr_pend_valid, .wr_pend_addr,
		.rd_req, .rd_req_valid, .rd_req_taken,
		.wr_req, .wr_req_valid, .wr_req_taken
	);

	axi_read_engine #(.IFETCH_BEATS(IFETCH_BEATS)) i_rd_engine (
		.aclk, .aresetn,
		.rd_req, .rd_req_valid, .rd_req_taken,
		.m_ar, .m_arvalid, .m_arready,
		.m_r, .m_rvalid, .m_rready,
		.ar_fire, .r_fire
	);

	axi_write_engine i_wr_engine (
		.aclk, .aresetn,
		.wr_req, .wr_req_valid, .wr_req_taken,
		.m_aw, .m_awvalid, .m_awready,
		.m_w, .m_wvalid, .m_wready,
		.m_b, .m_bvalid, .m_bready,
		.aw_fire, .b_fire,
		.wr_pend_valid, .wr_pend_addr
	);

	mem_resp_return #(.IFETCH_BEATS(IFETCH_BEATS)) i_return (
		.aclk, .aresetn,
		.ar_fire, .ar_id(m_ar.id), .aw_fire, .b_fire, .r_fire, .m_r,
		.icache_rd_rdy, .icache_ret_valid, .icache_ret_last, .icache_ret_data,
		.data_sram_addr_ok, .data_sram_data_ok, .data_sram_rdata
	);

endmodule

// File: verification/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
	parameter int HALF_PERIOD  = 4, // 8 ns clock
	parameter int RESET_CYCLES = 4
) (
	output logic aclk,
	output logic aresetn
);

	initial begin
		aclk = 1'b0;
		forever #(HALF_PERIOD) aclk = ~aclk;
	end

	initial begin
		aresetn = 1'b0;
		repeat (RESET_CYCLES) @(posedge aclk);
		#1 aresetn = 1'b1;
	end

endmodule

// File: verification/bridge_asserts.sv
`timescale 1ns/1ps

module bridge_asserts
	import axi3_pkg::*;
(
	input logic    aclk,
	input logic    aresetn,
	input axi_ar_t m_ar,
	input logic    m_arvalid,
	input logic    m_arready,
	input axi_aw_t m_aw,
	input logic    m_awvalid,
	input logic    m_awready,
	input axi_w_t  m_w,
	input logic    m_wvalid,
	input logic    m_wready,
	input logic    data_sram_addr_ok,
	input logic    data_sram_data_ok
);

	logic [3:0] open_cnt; // data requests accepted but not yet answered

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			open_cnt <= 4'd0;
		end else begin
			case ({data_sram_addr_ok, data_sram_data_ok})
				2'b10:   open_cnt <= open_cnt + 4'd1;
				2'b01:   open_cnt <= open_cnt - 4'd1;
				default: open_cnt <= open_cnt;
			endcase
		end
	end

	ar_hold: assert property (@(posedge aclk) disable iff (!aresetn)
		m_arvalid && !m_arready |=> m_arvalid && $stable(m_ar))
		else $error("AR valid dropped or payload changed before its handshake");

	aw_hold: assert property (@(posedge aclk) disable iff (!aresetn)
		m_awvalid && !m_awready |=> m_awvalid && $stable(m_aw))
		else $error("AW valid dropped or payload changed before its handshake");

	w_hold: assert property (@(posedge aclk) disable iff (!aresetn)
		m_wvalid && !m_wready |=> m_wvalid && $stable(m_w))
		else $error("W valid dropped or payload changed before its handshake");

	ok_order: assert property (@(posedge aclk) disable iff (!aresetn)
		data_sram_data_ok |-> open_cnt != 4'd0)
		else $error("data_ok without an earlier addr_ok");

endmodule

bind sram_axi_bridge bridge_asserts i_asserts (.*);

// File: verification/tb_sram_axi_bridge.sv
`timescale 1ns/1ps

module tb_sram_axi_bridge
	import axi3_pkg::*;
	import cpu_mem_pkg::*;
();

	localparam int TIMEOUT = 200;
	localparam int BEATS   = 4;

	typedef struct packed {
		int          test;
		req_kind_e   kind;
		logic [31:0] addr;
		logic [1:0]  size;
		logic [31:0] wdata;
		logic [3:0]  wstrb;
	} stim_t;

	typedef struct packed {
		logic        is_store;
		logic [7:0]  word;
		logic [31:0] data;
		logic        last;
	} exp_t;

	logic        aclk;
	logic        aresetn;
	logic        icache_rd_req;
	logic [31:0] icache_rd_addr;
	logic        icache_rd_rdy;
	logic        icache_ret_valid;
	logic        icache_ret_last;
	logic [31:0] icache_ret_data;
	logic        data_sram_req;
	logic        data_sram_wr;
	logic [1:0]  data_sram_size;
	logic [31:0] data_sram_addr;
	logic [31:0] data_sram_wdata;
	logic [3:0]  data_sram_wstrb;
	logic        data_sram_addr_ok;
	logic        data_sram_data_ok;
	logic [31:0] data_sram_rdata;
	axi_ar_t     m_ar;
	logic        m_arvalid;
	logic        m_arready;
	axi_r_t      m_r;
	logic        m_rvalid;
	logic        m_rready;
	axi_aw_t     m_aw;
	logic        m_awvalid;
	logic        m_awready;
	axi_w_t      m_w;
	logic        m_wvalid;
	logic        m_wready;
	axi_b_t      m_b;
	logic        m_bvalid;
	logic        m_bready;

	logic [31:0] mem [256];    // slave model storage
	logic [31:0] shadow [256]; // expected contents
	stim_t       stim_table [$];
	exp_t        data_exp [$];
	exp_t        fetch_exp [$];
	int          errors;
	int          checks;
	int          resp_errors;
	int          resp_checks;
	logic        timed_out;

	tb_clk_gen i_clk_gen (.aclk, .aresetn);

	sram_axi_bridge #(.IFETCH_BEATS(BEATS)) i_dut (.*);

	function automatic logic [31:0] initial_word(input int idx);
		return 32'(idx) ^ 32'hA5A5_0000;
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
		input logic [3:0] strb);
		logic [31:0] r;
		r = old;
		for (int b = 0; b < 4; b++)
			if (strb[b])
				r[8*b +: 8] = data[8*b +: 8];
		return r;
	endfunction

	function automatic logic store_open_other(input logic [7:0] word);
		foreach (data_exp[i])
			if (data_exp[i].is_store && data_exp[i].word != word)
				return 1'b1;
		return 1'b0;
	endfunction

	// AXI slave model samples handshakes at negedge and drives 1 ns after posedge
	initial begin : axi_slave
		logic    ar_hs;
		logic    aw_hs;
		logic    w_hs;
		logic    r_hs;
		logic    b_hs;
		axi_ar_t ar_s;
		axi_aw_t aw_s;
		axi_w_t  w_s;
		axi_aw_t aw_h;
		axi_w_t  w_h;
		axi_r_t  r_q [$];
		axi_aw_t aw_q [$];
		int      aw_due [$]; // cycle from which each queued write may land
		axi_w_t  w_q [$];
		axi_b_t  b_q [$];
		int      cyc;
		logic [7:0] widx;
		m_arready = 1'b0;
		m_awready = 1'b0;
		m_wready  = 1'b0;
		m_rvalid  = 1'b0;
		m_bvalid  = 1'b0;
		m_r       = '0;
		m_b       = '0;
		cyc       = 0;
		forever begin
			@(negedge aclk);
			ar_hs = m_arvalid && m_arready;
			aw_hs = m_awvalid && m_awready;
			w_hs  = m_wvalid && m_wready;
			r_hs  = m_rvalid && m_rready;
			b_hs  = m_bvalid && m_bready;
			ar_s  = m_ar;
			aw_s  = m_aw;
			w_s   = m_w;
			@(posedge aclk);
			#1;
			cyc++;
			if (ar_hs) begin // read data snapshot at address acceptance
				for (int i = 0; i <= int'(ar_s.len); i++) begin
					widx = ar_s.addr[9:2] + 8'(i);
					r_q.push_back('{id: ar_s.id, data: mem[widx], resp: 2'b00,
						last: (i == int'(ar_s.len))});
				end
			end
			if (aw_hs) begin
				aw_q.push_back(aw_s);
				aw_due.push_back(cyc + 6); // slow write, lands well after a following read
			end
			if (w_hs)
				w_q.push_back(w_s);
			if (aw_q.size() > 0 && w_q.size() > 0 && aw_due[0] <= cyc) begin
				aw_h = aw_q.pop_front();
				void'(aw_due.pop_front());
				w_h  = w_q.pop_front();
				mem[aw_h.addr[9:2]] = merge_bytes(mem[aw_h.addr[9:2]], w_h.data, w_h.strb);
				b_q.push_back('{id: aw_h.id, resp: 2'b00});
			end
			if (r_hs)
				void'(r_q.pop_front());
			if (b_hs)
				void'(b_q.pop_front());
			if (!(m_rvalid && !r_hs)) begin // a raised valid holds
				m_rvalid = (r_q.size() > 0) && ($urandom_range(3) != 0);
				if (r_q.size() > 0)
					m_r = r_q[0];
			end
			if (!(m_bvalid && !b_hs)) begin
				m_bvalid = (b_q.size() > 0) && ($urandom_range(3) != 0);
				if (b_q.size() > 0)
					m_b = b_q[0];
			end
			m_arready = ($urandom_range(3) != 0);
			m_awready = ($urandom_range(3) != 0);
			m_wready  = ($urandom_range(3) != 0);
		end
	end

	// CPU-side return checks
	initial begin : response_check
		exp_t e;
		resp_errors = 0;
		resp_checks = 0;
		forever begin
			@(negedge aclk);
			if (data_sram_data_ok) begin
				if (data_exp.size() == 0) begin
					$display("data_ok at %0t with no data request outstanding", $time);
					resp_errors++;
				end else begin
					e = data_exp.pop_front();
					resp_checks++;
					if (!e.is_store) begin
						assert (data_sram_rdata == e.data) else begin
							$display("FAILED %0t: load data %h, expected %h", $time,
								data_sram_rdata, e.data);
							resp_errors++;
						end
					end
				end
			end
			if (icache_ret_valid) begin
				if (fetch_exp.size() == 0) begin
					$display("refill beat at %0t with no refill outstanding", $time);
					resp_errors++;
				end else begin
					e = fetch_exp.pop_front();
					resp_checks++;
					assert (icache_ret_data == e.data && icache_ret_last == e.last) else begin
						$display("FAILED %0t: refill beat %h last %b, expected %h last %b",
							$time, icache_ret_data, icache_ret_last, e.data, e.last);
						resp_errors++;
					end
				end
			end
		end
	end

	task automatic issue_data(input stim_t s, output time t_ok);
		int n;
		n = 0;
		t_ok = 0;
		@(posedge aclk);
		#1;
		data_sram_req   = 1'b1;
		data_sram_wr    = (s.kind == REQ_STORE);
		data_sram_size  = s.size;
		data_sram_addr  = s.addr;
		data_sram_wdata = s.wdata;
		data_sram_wstrb = s.wstrb;
		do begin
			@(negedge aclk);
			n++;
		end while (!data_sram_addr_ok && n < TIMEOUT);
		if (!data_sram_addr_ok) begin
			$display("timeout: data request to %h not accepted within %0d cycles", s.addr, TIMEOUT);
			timed_out = 1'b1;
			errors++;
		end else if (s.kind == REQ_STORE) begin
			t_ok = $time;
			shadow[s.addr[9:2]] = merge_bytes(shadow[s.addr[9:2]], s.wdata, s.wstrb);
			data_exp.push_back('{is_store: 1'b1, word: s.addr[9:2], data: '0, last: 1'b0});
		end else begin
			t_ok = $time;
			data_exp.push_back('{is_store: 1'b0, word: s.addr[9:2], data: shadow[s.addr[9:2]],
				last: 1'b0});
		end
		@(posedge aclk);
		#1;
		data_sram_req = 1'b0;
	endtask

	task automatic issue_fetch(input logic [31:0] addr, output time t_ok);
		int         n;
		logic [7:0] w;
		n = 0;
		t_ok = 0;
		@(posedge aclk);
		#1;
		icache_rd_req  = 1'b1;
		icache_rd_addr = addr;
		do begin
			@(negedge aclk);
			n++;
		end while (!icache_rd_rdy && n < TIMEOUT);
		if (!icache_rd_rdy) begin
			$display("timeout: refill of %h not accepted within %0d cycles", addr, TIMEOUT);
			timed_out = 1'b1;
			errors++;
		end else begin
			t_ok = $time;
			for (int i = 0; i < BEATS; i++) begin
				w = addr[9:2] + 8'(i);
				fetch_exp.push_back('{is_store: 1'b0, word: w, data: shadow[w],
					last: (i == BEATS - 1)});
			end
		end
		@(posedge aclk);
		#1;
		icache_rd_req = 1'b0;
	endtask

	task automatic wait_drained(input logic data_only);
		int n;
		n = 0;
		while ((data_exp.size() > 0 || (!data_only && fetch_exp.size() > 0)) && n < TIMEOUT) begin
			@(negedge aclk);
			n++;
		end
		if (data_exp.size() > 0 || (!data_only && fetch_exp.size() > 0)) begin
			$display("timeout: responses still missing after %0d cycles", TIMEOUT);
			timed_out = 1'b1;
			errors++;
		end
	endtask

	// a store's B and another load's data_ok would share one pulse, so keep them apart
	task automatic apply_entry(input stim_t s);
		time t;
		case (s.kind)
			REQ_IFETCH: issue_fetch(s.addr, t);
			REQ_STORE: begin
				wait_drained(1'b1);
				if (!timed_out)
					issue_data(s, t);
			end
			default: begin
				if (store_open_other(s.addr[9:2]))
					wait_drained(1'b1);
				if (!timed_out)
					issue_data(s, t);
			end
		endcase
	endtask

	task automatic report_test(input int id, input string name, input int err0);
		$display("test %0d %s: %s", id, name, (errors + resp_errors == err0) ? "pass" : "mismatch");
	endtask

	task automatic run_group(input int id, input string name);
		int err0;
		err0 = errors + resp_errors;
		if (timed_out)
			return;
		foreach (stim_table[i])
			if (stim_table[i].test == id && !timed_out)
				apply_entry(stim_table[i]);
		if (!timed_out)
			wait_drained(1'b0);
		report_test(id, name, err0);
	endtask

	task automatic run_same_cycle();
		time   t_load;
		time   t_fetch;
		int    err0;
		stim_t s;
		err0 = errors + resp_errors;
		if (timed_out)
			return;
		s = '{test: 5, kind: REQ_LOAD, addr: 32'h2C, size: 2'd2, wdata: '0, wstrb: '0};
		fork
			issue_fetch(32'h200, t_fetch);
			issue_data(s, t_load);
		join
		checks++;
		assert (t_load <= t_fetch) else begin
			$display("FAILED %0t: load accepted at %0t, after refill at %0t", $time, t_load, t_fetch);
			errors++;
		end
		if (!timed_out)
			wait_drained(1'b0);
		report_test(5, "load and refill together", err0);
	endtask

	task automatic check_idle();
		int err0;
		err0 = errors + resp_errors;
		repeat (8) begin
			@(negedge aclk);
			checks++;
			assert (!(m_arvalid || m_awvalid || m_wvalid || m_rready || m_bready ||
				icache_rd_rdy || icache_ret_valid || data_sram_addr_ok || data_sram_data_ok))
			else begin
				$display("FAILED %0t: valid or strobe high before any request", $time);
				errors++;
			end
		end
		report_test(1, "idle after reset", err0);
	endtask

	task automatic build_table();
		stim_t       s;
		int          r;
		logic [7:0]  w;
		logic [1:0]  off;
		stim_table.push_back('{2, REQ_LOAD, 32'h40, 2'd2, 32'h0, 4'h0});
		stim_table.push_back('{3, REQ_IFETCH, 32'h100, 2'd2, 32'h0, 4'h0});
		stim_table.push_back('{4, REQ_STORE, 32'h81, 2'd0, 32'h0000_5A00, 4'b0010});
		stim_table.push_back('{4, REQ_LOAD, 32'h80, 2'd2, 32'h0, 4'h0});
		for (int i = 0; i < 40; i++) begin
			r = $urandom_range(2);
			w = 8'($urandom_range(95, 32)); // shares words with the refills below
			s.test  = 6;
			s.size  = 2'($urandom_range(2));
			off     = (s.size == 2'd0) ? 2'($urandom_range(3)) :
				(s.size == 2'd1) ? {1'($urandom_range(1)), 1'b0} : 2'b00;
			s.wdata = $urandom;
			s.wstrb = (s.size == 2'd2) ? 4'hF : (s.size == 2'd1) ? (4'b0011 << off) :
				(4'b0001 << off);
			s.addr  = {22'd0, w, off};
			case (r)
				0: begin
					s.kind = REQ_IFETCH;
					s.addr = 32'($urandom_range(23, 8)) << 4;
					s.size = 2'd2;
				end
				1: s.kind = REQ_LOAD;
				default: s.kind = REQ_STORE;
			endcase
			stim_table.push_back(s);
		end
	endtask

	initial begin
		void'($urandom(32'h96c8_cfd6));
		errors          = 0;
		checks          = 0;
		timed_out       = 1'b0;
		icache_rd_req   = 1'b0;
		icache_rd_addr  = '0;
		data_sram_req   = 1'b0;
		data_sram_wr    = 1'b0;
		data_sram_size  = '0;
		data_sram_addr  = '0;
		data_sram_wdata = '0;
		data_sram_wstrb = '0;
		for (int i = 0; i < 256; i++) begin
			mem[i]    = initial_word(i);
			shadow[i] = initial_word(i);
		end
		build_table();
		check_idle();
		run_group(2, "data load");
		run_group(3, "instruction refill");
		run_group(4, "store then load");
		run_same_cycle();
		run_group(6, "random mix");
		$display("checks %0d, errors %0d", checks + resp_checks, errors + resp_errors);
		if (errors + resp_errors == 0 && !timed_out)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// File: compile.f
rtl/axi3_pkg.sv
rtl/cpu_mem_pkg.sv
rtl/mem_req_decode.sv
rtl/axi_read_engine.sv
rtl/axi_write_engine.sv
rtl/mem_resp_return.sv
rtl/sram_axi_bridge.sv
verification/tb_clk_gen.sv
verification/bridge_asserts.sv
verification/tb_sram_axi_bridge.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, then look for the pass message in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f compile.f --top-module tb_sram_axi_bridge -o sim_tb \
	&& out=$(./obj_dir/sim_tb) \
	|| { echo "$out"; echo "simulation build or run failed"; exit 1; }
echo "$out"
echo "$out" | grep -qx "No errors" && exit 0 || exit 1
